//--- design/mipsIsaPkg.sv
// ======================================================================
// MIPS subset definitions
//   opcodeT, functT  instruction encodings
//   aluOpT           decoded ALU operation
//   ctrlT            full decoder output
//   retireT          one retired instruction, seen by the testbench
// ======================================================================
package mipsIsaPkg;

  // primary opcodes, instr[31:26]
  typedef enum logic [5:0] {
    opRType = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  // R-type funct field, instr[5:0]
  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functT;

  // aluAdd is zero so an all-zero control word is harmless
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOpT;

  typedef struct packed {
    logic  regDst;
    logic  aluSrcImm;
    logic  memToReg;
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    logic  jump;
    logic  jumpReg;
    logic  link;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        wrEn;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;
  } retireT;

endpackage

//--- design/wbPkg.sv
// ======================================================================
// Wishbone classic bus types
//   wbReqT  master request (cycle, strobe, write, word address, data)
//   wbRspT  slave response (acknowledge, read data)
// ======================================================================
package wbPkg;

  // adr is a word address, byte bits [1:0] dropped
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [29:0] adr;
    logic [31:0] datW;
  } wbReqT;

  // datR only meaningful while ack is high
  typedef struct packed {
    logic        ack;
    logic [31:0] datR;
  } wbRspT;

endpackage

//--- design/controlUnit.sv
// ======================================================================
// Instruction decoder
//   opcode and funct to the ctrlT control word and ALU operation
//   unknown encodings decode to all-zero control (no-op)
// ======================================================================
module controlUnit (
  input  logic [31:0]       instr,
  output mipsIsaPkg::ctrlT  ctrl
);
  import mipsIsaPkg::*;

  always_comb begin
    ctrl = '0;
    case (instr[31:26])
      opRType: begin
        // funct picks the ALU op, jr is the odd one
        case (instr[5:0])
          fnAdd: ctrl.aluOp = aluAdd;
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr:  ctrl.aluOp = aluOr;
          fnSlt: ctrl.aluOp = aluSlt;
          default: ;
        endcase
        if (instr[5:0] == fnJr) begin
          ctrl.jumpReg = 1'b1;
        end else if (instr[5:0] inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt}) begin
          ctrl.regDst   = 1'b1;
          ctrl.regWrite = 1'b1;
        end
      end
      opAddi: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite  = 1'b1;
      end
      opLw: begin
        // address = rs + sign-extended offset
        ctrl.aluSrcImm = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.memRead   = 1'b1;
      end
      opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      opBeq: begin
        // subtract, zero flag decides
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end
      opJ: ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ;
    endcase

    // a single instruction never both reads and writes memory
    assert (!(ctrl.memRead && ctrl.memWrite));
  end

endmodule

//--- design/regFile.sv
// ======================================================================
// General purpose register file
//   32 x 32-bit, two combinational read ports, one write port
//   register 0 hard-wired to zero
// ======================================================================
module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rdAddrA,
  input  logic [4:0]  rdAddrB,
  output logic [31:0] rdDataA,
  output logic [31:0] rdDataB,
  input  logic        wrEn,
  input  logic [4:0]  wrAddr,
  input  logic [31:0] wrData
);

  logic [31:0] regs [32];

  // write at the edge that ends the retiring cycle
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != 5'd0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // reads see the old value during the write cycle
  assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

  // storage of r0 must never pick up a write
  r0StaysZero: assert property (
    @(posedge clk) disable iff (!rst)
    regs[0] == 32'd0
  );

endmodule

//--- design/alu.sv
// ======================================================================
// 32-bit ALU
//   add, sub, and, or, signed slt
//   zero flag for any operation
// ======================================================================
module alu (
  input  logic [31:0]       opA,
  input  logic [31:0]       opB,
  input  mipsIsaPkg::aluOpT op,
  output logic [31:0]       result,
  output logic              zero
);
  import mipsIsaPkg::*;

  always_comb begin
    case (op)
      aluAdd: result = opA + opB;
      aluSub: result = opA - opB;
      aluAnd: result = opA & opB;
      aluOr:  result = opA | opB;
      // signed compare, opposite signs matter here
      aluSlt: result = {31'd0, $signed(opA) < $signed(opB)};
      default: result = '0;
    endcase
  end

  // beq uses this after a subtract
  assign zero = (result == 32'd0);

endmodule

//--- design/pcUnit.sv
// ======================================================================
// Program counter
//   pc register with asynchronous reset to resetPc
//   next-pc select: register jump, jump, taken branch, sequential
// ======================================================================
module pcUnit #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             stall,
  input  mipsIsaPkg::ctrlT ctrl,
  input  logic [31:0]      instr,
  input  logic [31:0]      regTarget,
  input  logic             aluZero,
  output logic [31:0]      pc,
  output logic [31:0]      pcPlus4
);

  logic [31:0] branchOff;
  logic [31:0] jumpTarget;
  logic [31:0] nextPc;

  assign pcPlus4 = pc + 32'd4;

  // sign-extended offset, word aligned
  assign branchOff  = {{14{instr[15]}}, instr[15:0], 2'b00};
  // region of pc + 4, then the 26-bit index
  assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00};

  // priority order matters, jr first
  always_comb begin
    if (ctrl.jumpReg) begin
      nextPc = regTarget;
    end else if (ctrl.jump) begin
      nextPc = jumpTarget;
    end else if (ctrl.branch && aluZero) begin
      nextPc = pcPlus4 + branchOff;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // hold while the load/store unit is busy
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= resetPc;
    end else if (!stall) begin
      pc <= nextPc;
    end
  end

endmodule

//--- design/lsuWb.sv
// ======================================================================
// Load/store unit
//   idle/bus/done FSM, one Wishbone classic transfer per lw or sw
//   stalls the core until the transfer has completed
// ======================================================================
module lsuWb (
  input  logic          clk,
  input  logic          rst,
  input  logic          memRead,
  input  logic          memWrite,
  input  logic [31:0]   addr,
  input  logic [31:0]   storeData,
  output wbPkg::wbReqT  wbReq,
  input  wbPkg::wbRspT  wbRsp,
  output logic          stall,
  output logic [31:0]   loadData
);

  typedef enum logic [1:0] {sIdle, sBus, sDone} lsuStateT;

  lsuStateT    state;
  logic        cycQ;
  logic        weQ;
  logic [29:0] adrQ;
  logic [31:0] datQ;
  logic        memOp;

  assign memOp = memRead || memWrite;

  // ==================================================================
  // control FSM
  // ==================================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= sIdle;
      cycQ  <= 1'b0;
      weQ   <= 1'b0;
    end else begin
      case (state)
        sIdle: if (memOp) begin
          state <= sBus;
          cycQ  <= 1'b1;
          weQ   <= memWrite;
        end
        // wait states only stretch this state
        sBus: if (wbRsp.ack) begin
          state <= sDone;
          cycQ  <= 1'b0;
          weQ   <= 1'b0;
        end
        // instruction retires here
        default: state <= sIdle;
      endcase
    end
  end

  // request payload, captured once in idle
  always_ff @(posedge clk) begin
    if (state == sIdle && memOp) begin
      adrQ <= addr[31:2];
      datQ <= storeData;
    end
  end

  // read data valid only with ack
  always_ff @(posedge clk) begin
    if (state == sBus && wbRsp.ack) begin
      loadData <= wbRsp.datR;
    end
  end

  // cyc and stb always move together
  assign wbReq = '{cyc: cycQ, stb: cycQ, we: weQ, adr: adrQ, datW: datQ};

  // busy from the first cycle of a memory instruction up to done
  assign stall = (state == sBus) || (state == sIdle && memOp);

  stbNeedsCyc: assert property (
    @(posedge clk) disable iff (!rst)
    wbReq.stb |-> wbReq.cyc
  );

  // request held until the slave acks
  reqStable: assert property (
    @(posedge clk) disable iff (!rst)
    (wbReq.stb && !wbRsp.ack) |=> ($stable(wbReq.adr) && $stable(wbReq.we))
  );

endmodule

//--- design/mipsCore.sv
// ======================================================================
// Single-cycle MIPS core
//   decode, register file, ALU, pc and load/store unit
//   immediate extension, write-back select, retire port
// ======================================================================
module mipsCore #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input  logic               clk,
  input  logic               rst,
  output logic [31:0]        imemAddr,
  input  logic [31:0]        imemData,
  output wbPkg::wbReqT       wbReq,
  input  wbPkg::wbRspT       wbRsp,
  output mipsIsaPkg::retireT retire
);
  import mipsIsaPkg::*;

  ctrlT        ctrl;
  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [31:0] immExt;
  logic [31:0] rdDataA;
  logic [31:0] rdDataB;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [31:0] loadData;
  logic        lsuStall;
  logic        runQ;
  logic        retValid;
  logic [4:0]  wrAddr;
  logic [31:0] wrData;

  // first cycle out of reset only fetches
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      runQ <= 1'b0;
    end else begin
      runQ <= 1'b1;
    end
  end

  assign imemAddr = pc;
  assign immExt   = {{16{imemData[15]}}, imemData[15:0]};
  assign aluB     = ctrl.aluSrcImm ? immExt : rdDataB;

  // ==================================================================
  // write-back
  // ==================================================================
  // r31 for link and rd for R-type or else rt
  assign wrAddr = ctrl.link ? 5'd31 : (ctrl.regDst ? imemData[15:11] : imemData[20:16]);

  always_comb begin
    if (ctrl.link) begin
      wrData = pcPlus4;
    end else if (ctrl.memToReg) begin
      wrData = loadData;
    end else begin
      wrData = aluResult;
    end
  end

  // retire only when nothing is pending
  assign retValid = runQ && !lsuStall;
  assign retire = '{valid: retValid, pc: pc, wrEn: retValid && ctrl.regWrite,
                    wrAddr: wrAddr, wrData: wrData};

  controlUnit uCtrl (.instr(imemData), .ctrl(ctrl));

  regFile uRegs (
    .clk(clk), .rst(rst),
    .rdAddrA(imemData[25:21]), .rdAddrB(imemData[20:16]),
    .rdDataA(rdDataA), .rdDataB(rdDataB),
    .wrEn(retire.wrEn), .wrAddr(wrAddr), .wrData(wrData)
  );

  alu uAlu (.opA(rdDataA), .opB(aluB), .op(ctrl.aluOp), .result(aluResult), .zero(aluZero));

  pcUnit #(.resetPc(resetPc)) uPc (
    .clk(clk), .rst(rst), .stall(lsuStall || !runQ), .ctrl(ctrl), .instr(imemData),
    .regTarget(rdDataA), .aluZero(aluZero), .pc(pc), .pcPlus4(pcPlus4)
  );

  lsuWb uLsu (
    .clk(clk), .rst(rst), .memRead(ctrl.memRead), .memWrite(ctrl.memWrite),
    .addr(aluResult), .storeData(rdDataB), .wbReq(wbReq), .wbRsp(wbRsp),
    .stall(lsuStall), .loadData(loadData)
  );

endmodule

//--- design/dataRam.sv
// ======================================================================
// Data RAM, Wishbone classic slave
//   2**dataAddrBits words of 32 bits
//   ack after dataWaitStates cycles, write on the ack cycle
// ======================================================================
module dataRam #(
  parameter int dataAddrBits   = 7,
  parameter int dataWaitStates = 1
) (
  input  logic         clk,
  input  logic         rst,
  input  wbPkg::wbReqT wbReq,
  output wbPkg::wbRspT wbRsp
);

  localparam int cntBits = (dataWaitStates > 0) ? $clog2(dataWaitStates + 1) : 1;

  logic [31:0]             mem [2**dataAddrBits];
  logic [cntBits-1:0]      waitCnt;
  logic [dataAddrBits-1:0] idx;
  logic                    ack;

  assign idx = wbReq.adr[dataAddrBits-1:0];
  // ack as soon as the count is reached, zero waits acks at once
  assign ack = wbReq.cyc && wbReq.stb && (waitCnt == cntBits'(dataWaitStates));

  // wait counter, back to zero on ack
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      waitCnt <= '0;
    end else if (ack) begin
      waitCnt <= '0;
    end else if (wbReq.cyc && wbReq.stb) begin
      waitCnt <= waitCnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 2**dataAddrBits; i++) begin
        mem[i] <= '0;
      end
    end else if (ack && wbReq.we) begin
      mem[idx] <= wbReq.datW;
    end
  end

  assign wbRsp = '{ack: ack, datR: ack ? mem[idx] : 32'd0};

endmodule

//--- design/mipsSystem.sv
// ======================================================================
// Processor subsystem top level
//   mipsCore plus Wishbone data RAM
//   external instruction port and retire port
// ======================================================================
module mipsSystem #(
  parameter logic [31:0] resetPc        = 32'h0,
  parameter int          dataAddrBits   = 7,
  parameter int          dataWaitStates = 1
) (
  input  logic               clk,
  input  logic               rst,
  output logic [31:0]        imemAddr,
  input  logic [31:0]        imemData,
  output mipsIsaPkg::retireT retire
);
  import wbPkg::*;

  // data bus between core and RAM
  wbReqT wbReq;
  wbRspT wbRsp;

  mipsCore #(.resetPc(resetPc)) uCore (
    .clk(clk),
    .rst(rst),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .wbReq(wbReq),
    .wbRsp(wbRsp),
    .retire(retire)
  );

  dataRam #(.dataAddrBits(dataAddrBits), .dataWaitStates(dataWaitStates)) uRam (
    .clk(clk),
    .rst(rst),
    .wbReq(wbReq),
    .wbRsp(wbRsp)
  );

endmodule

//--- dv/tbProgram.sv
// ======================================================================
// Testbench program and reference model
//   assembler helpers and the fixed test program
//   combinational instruction memory
//   instruction-set model stepped on every retired instruction
// ======================================================================
module tbProgram #(
  parameter logic [31:0] resetPc     = 32'h0,
  parameter int          ramAddrBits = 7
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [31:0]        imemAddr,
  output logic [31:0]        imemData,
  input  mipsIsaPkg::retireT retire,
  output mipsIsaPkg::retireT expRet,
  output logic               expMem,
  output logic               haltSeen
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] seedInit = 32'h3ceae04b;
  // subroutine and halt loop sit at fixed word slots of the program
  localparam logic [31:0] subPc    = resetPc + 32'd92;
  localparam logic [31:0] haltPc   = resetPc + 32'd100;

  // MIPS encodings, straight from the ISA tables
  localparam logic [5:0] opRType = 6'h00;
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opJal   = 6'h03;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opAddi  = 6'h08;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;
  localparam logic [5:0] fnJr    = 6'h08;
  localparam logic [5:0] fnAdd   = 6'h20;
  localparam logic [5:0] fnSub   = 6'h22;
  localparam logic [5:0] fnAnd   = 6'h24;
  localparam logic [5:0] fnOr    = 6'h25;
  localparam logic [5:0] fnSlt   = 6'h2a;

  logic [31:0]            imem [64];
  logic [31:0]            mReg [32];
  logic [31:0]            mMem [2**ramAddrBits];
  logic [31:0]            mPc;
  logic [31:0]            asmPc;
  logic [31:0]            nextPc;
  logic [31:0]            storeWord;
  logic [ramAddrBits-1:0] memIdx;
  logic                   isStore;
  int                     seed;

  // ====================================================================
  // assembler
  // ====================================================================
  function automatic logic [31:0] encR(input logic [5:0] fn, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [4:0] rd);
    return {opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // word index of the byte target
  function automatic logic [31:0] encJ(input logic [5:0] op, input logic [31:0] target);
    return {op, target[27:2]};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[asmPc[7:2]] = word;
    asmPc = asmPc + 32'd4;
  endtask

  initial begin
    logic [15:0] immA;
    logic [15:0] immB;
    logic [15:0] immZ;
    logic [15:0] offA;
    logic [15:0] offB;
    logic [15:0] offC;
    seed = seedInit;
    for (int i = 0; i < 64; i++) begin
      imem[i] = 32'd0;
    end
    // immA positive, immB negative, so slt sees opposite signs
    immA = 16'($random(seed)) & 16'h7fff;
    immB = 16'($random(seed)) | 16'h8000;
    immZ = 16'($random(seed));
    offA = 16'($random(seed)) & 16'h007c;
    offB = (offA + 16'd4) & 16'h007c;
    offC = offA ^ 16'h0040;
    asmPc = resetPc;
    emit(encI(opAddi, 5'd0, 5'd1, immA));
    emit(encI(opAddi, 5'd0, 5'd2, immB));
    emit(encR(fnAdd, 5'd1, 5'd2, 5'd3));
    emit(encR(fnSub, 5'd1, 5'd2, 5'd4));
    emit(encR(fnAnd, 5'd1, 5'd2, 5'd5));
    emit(encR(fnOr, 5'd1, 5'd2, 5'd6));
    emit(encR(fnSlt, 5'd2, 5'd1, 5'd7));
    emit(encR(fnSlt, 5'd1, 5'd2, 5'd8));
    // write to r0, then read it back through an add
    emit(encI(opAddi, 5'd0, 5'd0, immZ));
    emit(encR(fnAdd, 5'd0, 5'd1, 5'd9));
    // data base 0x80, stores then loads of same and other words
    emit(encI(opAddi, 5'd0, 5'd10, 16'h0080));
    emit(encI(opSw, 5'd10, 5'd1, offA));
    emit(encI(opSw, 5'd10, 5'd2, offB));
    emit(encI(opLw, 5'd10, 5'd11, offB));
    emit(encI(opLw, 5'd10, 5'd12, offA));
    emit(encI(opLw, 5'd10, 5'd13, offC));
    // taken branch skips the next addi
    emit(encI(opBeq, 5'd11, 5'd2, 16'd1));
    emit(encI(opAddi, 5'd0, 5'd14, 16'd1));
    emit(encI(opBeq, 5'd1, 5'd2, 16'd1));
    emit(encI(opAddi, 5'd0, 5'd15, 16'd2));
    // undefined opcode, must act as a no-op
    emit(32'hfc00_0000);
    emit(encJ(opJal, subPc));
    emit(encJ(opJ, haltPc));
    // subroutine
    emit(encI(opAddi, 5'd31, 5'd16, 16'd0));
    emit(encR(fnJr, 5'd31, 5'd0, 5'd0));
    // halt loop
    emit(encJ(opJ, haltPc));
  end

  assign imemData = imem[imemAddr[7:2]];

  // ====================================================================
  // reference model
  // ====================================================================
  // expected retire of the instruction at the model pc
  always_comb begin
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] pc4;
    logic [31:0] addr;
    w    = imem[mPc[7:2]];
    a    = mReg[w[25:21]];
    b    = mReg[w[20:16]];
    imm  = {{16{w[15]}}, w[15:0]};
    pc4  = mPc + 32'd4;
    addr = a + imm;
    expRet       = '0;
    expRet.valid = 1'b1;
    expRet.pc    = mPc;
    expMem       = 1'b0;
    isStore      = 1'b0;
    storeWord    = b;
    memIdx       = addr[ramAddrBits+1:2];
    nextPc       = pc4;
    case (w[31:26])
      opRType: begin
        expRet.wrAddr = w[15:11];
        expRet.wrEn   = w[5:0] inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt};
        case (w[5:0])
          fnAdd: expRet.wrData = a + b;
          fnSub: expRet.wrData = a - b;
          fnAnd: expRet.wrData = a & b;
          fnOr:  expRet.wrData = a | b;
          fnSlt: expRet.wrData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          fnJr:  nextPc = a;
          default: ;
        endcase
      end
      opAddi: begin
        expRet.wrEn   = 1'b1;
        expRet.wrAddr = w[20:16];
        expRet.wrData = addr;
      end
      opLw: begin
        expMem        = 1'b1;
        expRet.wrEn   = 1'b1;
        expRet.wrAddr = w[20:16];
        expRet.wrData = mMem[memIdx];
      end
      opSw: begin
        expMem  = 1'b1;
        isStore = 1'b1;
      end
      opBeq: if (a == b) begin
        nextPc = pc4 + {imm[29:0], 2'b00};
      end
      opJ: nextPc = {pc4[31:28], w[25:0], 2'b00};
      // no delay slot, link is pc + 4
      opJal: begin
        expRet.wrEn   = 1'b1;
        expRet.wrAddr = 5'd31;
        expRet.wrData = pc4;
        nextPc        = {pc4[31:28], w[25:0], 2'b00};
      end
      default: ;
    endcase
  end

  // one model step per retired instruction
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mPc      <= resetPc;
      haltSeen <= 1'b0;
      for (int i = 0; i < 32; i++) begin
        mReg[i] <= '0;
      end
      for (int i = 0; i < 2**ramAddrBits; i++) begin
        mMem[i] <= '0;
      end
    end else if (retire.valid) begin
      if (expRet.wrEn && expRet.wrAddr != 5'd0) begin
        mReg[expRet.wrAddr] <= expRet.wrData;
      end
      if (isStore) begin
        mMem[memIdx] <= storeWord;
      end
      if (mPc == haltPc) begin
        haltSeen <= 1'b1;
      end
      mPc <= nextPc;
    end
  end

endmodule

//--- dv/tbMipsSystem.sv
// ======================================================================
// Testbench top for the MIPS subsystem
//   clock, reset, UUT, program and model instance
//   retire checks as concurrent assertions
// ======================================================================
module tbMipsSystem;
  timeunit 1ns;
  timeprecision 100ps;
  import mipsIsaPkg::*;

  localparam logic [31:0] resetPc    = 32'h0000_0040;
  localparam int          addrBits   = 7;
  localparam int          waitStates = 2;
  localparam int          runTimeout = 2000;

  logic        clk;
  logic        rst;
  logic [31:0] imemAddr;
  logic [31:0] imemData;
  retireT      retire;
  retireT      expRet;
  logic        expMem;
  logic        haltSeen;
  int          idleCycles;

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  mipsSystem #(
    .resetPc(resetPc),
    .dataAddrBits(addrBits),
    .dataWaitStates(waitStates)
  ) UUT (
    .clk(clk),
    .rst(rst),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .retire(retire)
  );

  tbProgram #(.resetPc(resetPc), .ramAddrBits(addrBits)) prog (
    .clk(clk),
    .rst(rst),
    .imemAddr(imemAddr),
    .imemData(imemData),
    .retire(retire),
    .expRet(expRet),
    .expMem(expMem),
    .haltSeen(haltSeen)
  );

  task automatic abortRun();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] want);
    $display("Mismatch %s got %h expected %h", sig, got, want);
    abortRun();
  endtask

  // cycles without a retire since the last one
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      idleCycles <= 0;
    end else if (retire.valid) begin
      idleCycles <= 0;
    end else begin
      idleCycles <= idleCycles + 1;
    end
  end

  // ====================================================================
  // checks against the reference model
  // ====================================================================
  noRetireInReset: assert property (@(posedge clk) !rst |-> !retire.valid)
    else begin
      $display("retire seen while reset was asserted");
      abortRun();
    end

  // pc held while a memory op is pending, then follows program order
  fetchPc: assert property (@(posedge clk) disable iff (!rst) imemAddr == expRet.pc)
    else mismatch("imemAddr", $sampled(imemAddr), $sampled(expRet.pc));

  retirePc: assert property (
    @(posedge clk) disable iff (!rst)
    retire.valid |-> (retire.pc == expRet.pc)
  ) else mismatch("retire.pc", $sampled(retire.pc), $sampled(expRet.pc));

  // a write to r0 may show up with wrEn low
  retireWrEn: assert property (
    @(posedge clk) disable iff (!rst)
    (retire.valid && !(expRet.wrEn && expRet.wrAddr == 5'd0)) |->
      (retire.wrEn == expRet.wrEn)
  ) else mismatch("retire.wrEn", 32'($sampled(retire.wrEn)), 32'($sampled(expRet.wrEn)));

  retireWrAddr: assert property (
    @(posedge clk) disable iff (!rst)
    (retire.valid && expRet.wrEn && expRet.wrAddr != 5'd0) |->
      (retire.wrAddr == expRet.wrAddr)
  ) else mismatch("retire.wrAddr", 32'($sampled(retire.wrAddr)),
                  32'($sampled(expRet.wrAddr)));

  retireWrData: assert property (
    @(posedge clk) disable iff (!rst)
    (retire.valid && expRet.wrEn && expRet.wrAddr != 5'd0) |->
      (retire.wrData == expRet.wrData)
  ) else mismatch("retire.wrData", $sampled(retire.wrData), $sampled(expRet.wrData));

  // idle, bus and done at the least, so two silent cycles before
  memLatency: assert property (
    @(posedge clk) disable iff (!rst)
    (retire.valid && expMem) |-> (idleCycles >= 2)
  ) else begin
    $display("memory instruction retired before its bus transfer finished");
    abortRun();
  end

  // ====================================================================
  // stimulus
  // ====================================================================
  initial begin
    int cycles;
    rst = 1'b0;
    repeat (16) @(negedge clk);
    rst = 1'b1;
    cycles = 0;
    // run until the model has retired the halt loop once
    while (!haltSeen && cycles < runTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!haltSeen) begin
      $display("timeout after %0d cycles without reaching the halt loop", runTimeout);
      abortRun();
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- tb.f
design/mipsIsaPkg.sv
design/wbPkg.sv
design/controlUnit.sv
design/regFile.sv
design/alu.sv
design/pcUnit.sv
design/lsuWb.sv
design/mipsCore.sv
design/dataRam.sv
design/mipsSystem.sv
dv/tbProgram.sv
dv/tbMipsSystem.sv

//--- run.sh
#!/bin/sh
# build and run the MIPS subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tbMipsSystem -f tb.f -o simv

# the simulator exits non-zero on failure, the log decides
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qF '** FAIL **' sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -qF '** PASS **' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
